// ==== logic/ramio_cfg_pkg.sv ====
/*
  Sizing and timing constants for the RAM/IO subsystem.
  Clock and baud values are simulation defaults and give 8 clocks per bit.
  Board builds must override them at the top level.
*/

package ramio_cfg_pkg;

  // memory sizing
  localparam int RAM_ADDRESS_BITWIDTH = 12;  // byte address, 4 KB
  localparam int CACHE_LINE_INDEX_BITWIDTH = 3;  // 8 lines of 8 bytes

  // serial timing
  localparam int CLOCK_FREQUENCY_HZ = 8_000_000;
  localparam int UART_BAUD_RATE = 1_000_000;

  // burst ram: cycles from read cmd_en to rd_data_valid
  localparam int RAM_READ_LATENCY = 3;

endpackage

// ==== logic/ramio_bus_pkg.sv ====
/*
  Encodings of the requester bus, the burst command port and the I/O map.
  Addresses at or above ADDR_UART_OUT are I/O, everything else is RAM.
*/

package ramio_bus_pkg;

  // load type, bit 2 selects zero extension
  typedef enum logic [2:0] {
    RT_NONE   = 3'd0,
    RT_BYTE   = 3'd1,
    RT_HALF   = 3'd2,
    RT_WORD   = 3'd3,
    RT_BYTE_U = 3'd5,
    RT_HALF_U = 3'd6
  } read_type_t;

  typedef enum logic [1:0] {
    WT_NONE = 2'd0,
    WT_BYTE = 2'd1,
    WT_HALF = 2'd2,
    WT_WORD = 2'd3
  } write_type_t;

  // burst ram commands, same sense as the psram controller
  localparam logic BR_CMD_READ = 1'b0;
  localparam logic BR_CMD_WRITE = 1'b1;

  // --------------------
  // i/o map, top of the address space
  localparam logic [31:0] ADDR_LED = 32'hFFFF_FFFF;  // low 4 bits drive led
  localparam logic [31:0] ADDR_UART_OUT = 32'hFFFF_FFFE;  // byte write sends

endpackage

// ==== logic/burst_ram.sv ====
/*
  Line-wide on-chip ram standing in for the psram controller.
  Fixed read latency, no back-pressure, contents start at zero.
*/
`timescale 1ns/1ps

module burst_ram
  import ramio_bus_pkg::*;
#(
    parameter int RamAddressBitWidth = 12,
    parameter int RamReadLatency = 3
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          br_cmd,  // 0 read, 1 write
    input  logic                          br_cmd_en,
    input  logic [RamAddressBitWidth-4:0] br_addr,  // line address
    input  logic [                  63:0] br_wr_data,
    output logic [                  63:0] br_rd_data,
    output logic                          br_rd_data_valid
);

  localparam int Lines = 2 ** (RamAddressBitWidth - 3);

  logic [63:0] mem[Lines];
  logic [63:0] rd_pipe[RamReadLatency];
  logic [RamReadLatency-1:0] valid_pipe;

  initial begin
    for (int i = 0; i < Lines; i++) mem[i] = '0;
  end

  // array and read data pipe
  always_ff @(posedge clk) begin
    if (br_cmd_en && br_cmd == BR_CMD_WRITE) mem[br_addr] <= br_wr_data;
    rd_pipe[0] <= mem[br_addr];
    for (int i = 1; i < RamReadLatency; i++) rd_pipe[i] <= rd_pipe[i-1];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= br_cmd_en && br_cmd == BR_CMD_READ;
      for (int i = 1; i < RamReadLatency; i++) valid_pipe[i] <= valid_pipe[i-1];
    end
  end

  assign br_rd_data = rd_pipe[RamReadLatency-1];
  assign br_rd_data_valid = valid_pipe[RamReadLatency-1];

endmodule

// ==== logic/line_cache.sv ====
/*
  Direct-mapped write-back cache of 64-bit lines over the burst ram port.
  c_ inputs must stay stable from c_enable until c_done.
  Hit answers in one cycle; a dirty miss writes back before the fill.
*/
`timescale 1ns/1ps

module line_cache
  import ramio_bus_pkg::*;
#(
    parameter int RamAddressBitWidth = 12,
    parameter int CacheLineIndexBitWidth = 3
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // requester side
    input  logic                          c_enable,
    input  logic                          c_write,
    input  logic [RamAddressBitWidth-4:0] c_line_address,
    input  logic [                  63:0] c_wr_data,
    input  logic [                   7:0] c_wr_mask,
    output logic [                  63:0] c_rd_data,
    output logic                          c_done,
    // burst ram side
    output logic                          br_cmd,
    output logic                          br_cmd_en,
    output logic [RamAddressBitWidth-4:0] br_addr,
    output logic [                  63:0] br_wr_data,
    input  logic [                  63:0] br_rd_data,
    input  logic                          br_rd_data_valid
);

  localparam int LineAddrBits = RamAddressBitWidth - 3;
  localparam int IdxBits = CacheLineIndexBitWidth;
  localparam int TagBits = LineAddrBits - IdxBits;
  localparam int Lines = 2 ** IdxBits;

  typedef enum logic [1:0] {CL_IDLE, CL_EVICT, CL_FILL} state_t;

  state_t state;
  logic [63:0] line_data[Lines];
  logic [TagBits-1:0] line_tag[Lines];
  logic [Lines-1:0] line_valid;
  logic [Lines-1:0] line_dirty;
  logic [IdxBits-1:0] idx;
  logic [TagBits-1:0] tag;
  logic hit;

  assign idx = c_line_address[IdxBits-1:0];
  assign tag = c_line_address[LineAddrBits-1:IdxBits];
  assign hit = line_valid[idx] && (line_tag[idx] == tag);

  // byte-wise merge of store data into a line
  function automatic logic [63:0] merge(input logic [63:0] old_line, input logic [63:0] new_line,
                                        input logic [7:0] mask);
    logic [63:0] res;
    res = old_line;
    for (int i = 0; i < 8; i++) begin
      if (mask[i]) res[i*8+:8] = new_line[i*8+:8];
    end
    return res;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= CL_IDLE;
      line_valid <= '0;  // all lines invalid
      line_dirty <= '0;
      br_cmd <= BR_CMD_READ;
      br_cmd_en <= 1'b0;
      c_done <= 1'b0;
    end else begin
      br_cmd_en <= 1'b0;  // single-cycle command
      c_done <= 1'b0;
      case (state)
        CL_IDLE: begin
          if (c_enable) begin
            if (hit) begin
              c_rd_data <= line_data[idx];
              c_done <= 1'b1;
              if (c_write) begin
                line_data[idx] <= merge(line_data[idx], c_wr_data, c_wr_mask);
                line_dirty[idx] <= 1'b1;
              end
            end else if (line_valid[idx] && line_dirty[idx]) begin
              // victim goes out first
              br_cmd_en <= 1'b1;
              br_cmd <= BR_CMD_WRITE;
              br_addr <= {line_tag[idx], idx};
              br_wr_data <= line_data[idx];
              state <= CL_EVICT;
            end else begin
              br_cmd_en <= 1'b1;
              br_cmd <= BR_CMD_READ;
              br_addr <= c_line_address;
              state <= CL_FILL;
            end
          end
        end
        CL_EVICT: begin
          // write was taken last cycle, request the new line
          br_cmd_en <= 1'b1;
          br_cmd <= BR_CMD_READ;
          br_addr <= c_line_address;
          line_dirty[idx] <= 1'b0;
          state <= CL_FILL;
        end
        default: begin  // CL_FILL
          if (br_rd_data_valid) begin
            line_data[idx] <= c_write ? merge(br_rd_data, c_wr_data, c_wr_mask) : br_rd_data;
            line_tag[idx] <= tag;
            line_valid[idx] <= 1'b1;
            line_dirty[idx] <= c_write;  // stores land in the cache only
            c_rd_data <= br_rd_data;
            c_done <= 1'b1;
            state <= CL_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== logic/io_regs.sv ====
/*
  LED register and one-byte uart staging.
  A new io_write must not arrive before io_done of the previous one.
*/
`timescale 1ns/1ps

module io_regs (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       io_write,
    input  logic       io_sel_uart,  // 1 uart, 0 led
    input  logic [7:0] io_byte,
    output logic [3:0] led_value,
    output logic       io_done,
    output logic       tx_valid,
    output logic [7:0] tx_byte,
    input  logic       tx_ready
);

  logic led_done;  // led write finished last edge

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_value <= 4'b0;
      led_done <= 1'b0;
      tx_valid <= 1'b0;
    end else begin
      led_done <= io_write && !io_sel_uart;
      if (io_write && !io_sel_uart) led_value <= io_byte[3:0];
      if (io_write && io_sel_uart) begin
        tx_valid <= 1'b1;  // held until uart_tx takes it
        tx_byte  <= io_byte;
      end else if (tx_valid && tx_ready) begin
        tx_valid <= 1'b0;
      end
    end
  end

  // uart write ends on the handoff cycle
  assign io_done = led_done || (tx_valid && tx_ready);

endmodule

// ==== logic/uart_tx.sv ====
/*
  8N1 transmitter. ClockFrequencyHz/BaudRate clocks per bit, truncated.
  tx_ready is high only while the line is idle.
*/
`timescale 1ns/1ps

module uart_tx #(
    parameter int ClockFrequencyHz = 8_000_000,
    parameter int BaudRate = 1_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       tx_ready,
    output logic       uart_tx
);

  localparam int ClksPerBit = ClockFrequencyHz / BaudRate;
  localparam int CntBits = $clog2(ClksPerBit + 1);

  logic active;
  logic [CntBits-1:0] clk_cnt;
  logic [3:0] bits_left;  // data bits plus stop
  logic [8:0] shreg;  // {stop, data}

  assign tx_ready = !active;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
      uart_tx <= 1'b1;  // idle high
      clk_cnt <= '0;
      bits_left <= '0;
    end else if (!active) begin
      if (tx_valid) begin
        active <= 1'b1;
        uart_tx <= 1'b0;  // start bit
        shreg <= {1'b1, tx_byte};
        clk_cnt <= '0;
        bits_left <= 4'd9;
      end
    end else if (clk_cnt == CntBits'(ClksPerBit - 1)) begin
      clk_cnt <= '0;
      if (bits_left == 4'd0) begin
        active <= 1'b0;  // stop bit done
      end else begin
        uart_tx <= shreg[0];  // lsb first
        shreg <= {1'b1, shreg[8:1]};
        bits_left <= bits_left - 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

// ==== logic/ramio.sv ====
/*
  Requester bus bridge. One access at a time; enable while busy is ignored.
  Misaligned or line-crossing accesses are undefined.
  Only ADDR_LED is readable on the I/O side, other I/O reads return 0.
*/
`timescale 1ns/1ps

module ramio
  import ramio_bus_pkg::*;
#(
    parameter int RamAddressBitWidth = 12
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // requester bus
    input  logic                          enable,
    input  read_type_t                    read_type,
    input  write_type_t                   write_type,
    input  logic [                  31:0] address,
    input  logic [                  31:0] data_in,
    output logic [                  31:0] data_out,
    output logic                          data_out_ready,
    output logic                          busy,
    // cache side
    output logic                          c_enable,
    output logic                          c_write,
    output logic [RamAddressBitWidth-4:0] c_line_address,
    output logic [                  63:0] c_wr_data,
    output logic [                   7:0] c_wr_mask,
    input  logic [                  63:0] c_rd_data,
    input  logic                          c_done,
    // i/o side
    output logic                          io_write,
    output logic                          io_sel_uart,
    output logic [                   7:0] io_byte,
    input  logic                          io_done,
    input  logic [                   3:0] led_value
);

  typedef enum logic [1:0] {ST_IDLE, ST_CACHE, ST_IO_WR, ST_IO_RD} state_t;

  state_t state;
  read_type_t rd_type_q;  // load type of the access in flight
  logic [2:0] off_q;  // byte offset inside the line
  logic is_io;
  logic [63:0] wr_lanes;
  logic [7:0] wr_mask;
  logic [63:0] rd_shift;
  logic [31:0] load_value;

  assign is_io = address >= ADDR_UART_OUT;

  // replicate store data over all lanes, mask picks the live ones
  always_comb begin
    case (write_type)
      WT_BYTE: begin
        wr_lanes = {8{data_in[7:0]}};
        wr_mask  = 8'h01 << address[2:0];
      end
      WT_HALF: begin
        wr_lanes = {4{data_in[15:0]}};
        wr_mask  = 8'h03 << address[2:0];
      end
      WT_WORD: begin
        wr_lanes = {2{data_in}};
        wr_mask  = 8'h0f << address[2:0];
      end
      default: begin
        wr_lanes = '0;
        wr_mask  = '0;
      end
    endcase
  end

  // load lanes down to bit 0, then extend
  assign rd_shift = c_rd_data >> {off_q, 3'b000};

  always_comb begin
    case (rd_type_q)
      RT_BYTE:   load_value = {{24{rd_shift[7]}}, rd_shift[7:0]};
      RT_HALF:   load_value = {{16{rd_shift[15]}}, rd_shift[15:0]};
      RT_BYTE_U: load_value = {24'b0, rd_shift[7:0]};
      RT_HALF_U: load_value = {16'b0, rd_shift[15:0]};
      default:   load_value = rd_shift[31:0];  // word
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      busy <= 1'b0;
      data_out_ready <= 1'b0;
      c_enable <= 1'b0;
      io_write <= 1'b0;
    end else begin
      data_out_ready <= 1'b0;  // pulses
      c_enable <= 1'b0;
      io_write <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (enable) begin
            busy <= 1'b1;
            rd_type_q <= read_type;
            off_q <= address[2:0];
            io_sel_uart <= address == ADDR_UART_OUT;
            io_byte <= data_in[7:0];
            if (is_io) begin
              io_write <= write_type != WT_NONE;
              state <= (write_type != WT_NONE) ? ST_IO_WR : ST_IO_RD;
            end else begin
              c_enable <= 1'b1;
              c_write <= write_type != WT_NONE;
              c_line_address <= address[RamAddressBitWidth-1:3];  // wraps mod ram size
              c_wr_data <= wr_lanes;
              c_wr_mask <= wr_mask;
              state <= ST_CACHE;
            end
          end
        end
        ST_CACHE: begin
          if (c_done) begin
            busy <= 1'b0;
            data_out_ready <= !c_write;
            data_out <= load_value;
            state <= ST_IDLE;
          end
        end
        ST_IO_WR: begin
          if (io_done) begin  // uart waits here for tx handoff
            busy <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: begin  // ST_IO_RD, led answered locally
          data_out <= io_sel_uart ? 32'b0 : {28'b0, led_value};
          data_out_ready <= 1'b1;
          busy <= 1'b0;
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== logic/ramio_top.sv ====
/*
  Memory and I/O subsystem, single clock domain.
  The requester bus follows the enable/busy protocol of ramio.
  Parameter defaults suit simulation; board values are passed in here.
*/
`timescale 1ns/1ps

module ramio_top
  import ramio_cfg_pkg::*, ramio_bus_pkg::*;
#(
    parameter int RamAddressBitWidth = RAM_ADDRESS_BITWIDTH,
    parameter int CacheLineIndexBitWidth = CACHE_LINE_INDEX_BITWIDTH,
    parameter int ClockFrequencyHz = CLOCK_FREQUENCY_HZ,
    parameter int BaudRate = UART_BAUD_RATE,
    parameter int RamReadLatency = RAM_READ_LATENCY
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  read_type_t  read_type,
    input  write_type_t write_type,
    input  logic [31:0] address,
    input  logic [31:0] data_in,
    output logic [31:0] data_out,
    output logic        data_out_ready,
    output logic        busy,
    output logic [ 3:0] led,
    output logic        uart_tx
);

  // --------------------
  // ramio to cache
  logic c_enable;
  logic c_write;
  logic [RamAddressBitWidth-4:0] c_line_address;
  logic [63:0] c_wr_data;
  logic [7:0] c_wr_mask;
  logic [63:0] c_rd_data;
  logic c_done;

  // cache to burst ram
  logic br_cmd;
  logic br_cmd_en;
  logic [RamAddressBitWidth-4:0] br_addr;
  logic [63:0] br_wr_data;
  logic [63:0] br_rd_data;
  logic br_rd_data_valid;

  // --------------------
  // i/o path
  logic io_write;
  logic io_sel_uart;
  logic [7:0] io_byte;
  logic io_done;
  logic tx_valid;
  logic [7:0] tx_byte;
  logic tx_ready;

  ramio #(
      .RamAddressBitWidth(RamAddressBitWidth)
  ) ramio_inst (
      .clk, .rst_n,
      .enable, .read_type, .write_type, .address, .data_in,
      .data_out, .data_out_ready, .busy,
      .c_enable, .c_write, .c_line_address, .c_wr_data, .c_wr_mask,
      .c_rd_data, .c_done,
      .io_write, .io_sel_uart, .io_byte, .io_done,
      .led_value(led)  // led reads served from the register
  );

  line_cache #(
      .RamAddressBitWidth(RamAddressBitWidth),
      .CacheLineIndexBitWidth(CacheLineIndexBitWidth)
  ) line_cache_inst (
      .clk, .rst_n,
      .c_enable, .c_write, .c_line_address, .c_wr_data, .c_wr_mask,
      .c_rd_data, .c_done,
      .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_rd_data, .br_rd_data_valid
  );

  burst_ram #(
      .RamAddressBitWidth(RamAddressBitWidth),
      .RamReadLatency(RamReadLatency)
  ) burst_ram_inst (
      .clk, .rst_n,
      .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_rd_data, .br_rd_data_valid
  );

  io_regs io_regs_inst (
      .clk, .rst_n,
      .io_write, .io_sel_uart, .io_byte,
      .led_value(led),
      .io_done, .tx_valid, .tx_byte, .tx_ready
  );

  uart_tx #(
      .ClockFrequencyHz(ClockFrequencyHz),
      .BaudRate(BaudRate)
  ) uart_tx_inst (
      .clk, .rst_n,
      .tx_valid, .tx_byte, .tx_ready,
      .uart_tx
  );

endmodule

// ==== test/ramio_tb_model.svh ====
/*
  Reference model of the RAM/IO subsystem, included inside ramio_tb.
  RAM is a byte array, addresses wrap modulo its size; accesses are aligned.
  Needs RamBytes and the two package imports of the including module.
*/
`ifndef RAMIO_TB_MODEL_SVH
`define RAMIO_TB_MODEL_SVH

logic [7:0] model_mem[RamBytes];  // byte image of the burst ram
logic [3:0] model_led;
logic [7:0] uart_q[$];  // bytes still due on uart_tx

function automatic void clear_model();
  for (int i = 0; i < RamBytes; i++) model_mem[i] = 8'h00;  // ram starts zeroed
  model_led = 4'h0;
  uart_q.delete();
endfunction

function automatic logic [7:0] byte_at(input logic [31:0] addr);
  return model_mem[addr[RAM_ADDRESS_BITWIDTH-1:0]];  // wraps mod ram size
endfunction

// store rule: led takes low nibble, uart queues the byte, ram takes 1/2/4 bytes
function automatic void apply_store(input logic [31:0] addr, input write_type_t wt,
                                    input logic [31:0] data);
  int n;
  logic [31:0] b;
  n = (wt == WT_BYTE) ? 1 : (wt == WT_HALF) ? 2 : 4;
  if (addr == ADDR_LED) begin
    model_led = data[3:0];
  end else if (addr == ADDR_UART_OUT) begin
    uart_q.push_back(data[7:0]);
  end else begin
    for (int i = 0; i < n; i++) begin
      b = addr + 32'(i);
      model_mem[b[RAM_ADDRESS_BITWIDTH-1:0]] = data[i*8+:8];  // little endian
    end
  end
endfunction

// load rule from read_type_t, bit 2 means zero extension
function automatic logic [31:0] expected_load(input logic [31:0] addr, input read_type_t rt);
  logic [31:0] raw;
  if (addr == ADDR_LED) return {28'b0, model_led};
  if (addr >= ADDR_UART_OUT) return 32'b0;  // uart not readable
  raw = {byte_at(addr + 32'd3), byte_at(addr + 32'd2), byte_at(addr + 32'd1), byte_at(addr)};
  case (rt)
    RT_BYTE:   return {{24{raw[7]}}, raw[7:0]};
    RT_HALF:   return {{16{raw[15]}}, raw[15:0]};
    RT_BYTE_U: return {24'b0, raw[7:0]};
    RT_HALF_U: return {16'b0, raw[15:0]};
    default:   return raw;
  endcase
endfunction

`endif

// ==== test/ramio_tb.sv ====
/*
  Testbench for ramio_top, stands in for the cpu core on the requester bus.
  Inputs change on the falling edge, outputs are sampled there too.
  Uart checks assume ClockFrequencyHz/BaudRate clocks per bit from ramio_cfg_pkg.
*/
`timescale 1ns/1ps

module ramio_tb
  import ramio_cfg_pkg::*, ramio_bus_pkg::*;
;

  localparam int RamBytes = 2 ** RAM_ADDRESS_BITWIDTH;
  localparam int ClksPerBit = CLOCK_FREQUENCY_HZ / UART_BAUD_RATE;
  localparam int WaitLimit = 40 * ClksPerBit;  // more cycles than two uart frames

  logic clk = 1'b0;
  logic rst_n;
  logic enable;
  read_type_t read_type;
  write_type_t write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic data_out_ready;
  logic busy;
  logic [3:0] led;
  logic uart_tx;

  logic [31:0] rng_state = 32'h68fa_3c7d;
  logic [31:0] expect_q[$];  // load results still owed by the dut

  `include "ramio_tb_model.svh"

  always #2 clk = ~clk;  // 4 ns period

  ramio_top ramio_top_inst (
      .clk, .rst_n, .enable, .read_type, .write_type, .address, .data_in,
      .data_out, .data_out_ready, .busy, .led, .uart_tx
  );

  // --------------------
  // reporting
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("ramio_tb: %s", what);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // one bus transaction from a falling edge until busy falls
  task automatic bus_access(input logic [31:0] addr, input write_type_t wt, input read_type_t rt,
                            input logic [31:0] wdata);
    int waited;
    waited = 0;
    while (busy !== 1'b0 && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (busy !== 1'b0) fail_run("busy never fell before a new access");
    if (wt != WT_NONE) apply_store(addr, wt, wdata);
    else expect_q.push_back(expected_load(addr, rt));
    enable = 1'b1;  // single-cycle request
    address = addr;
    write_type = wt;
    read_type = rt;
    data_in = wdata;
    @(negedge clk);
    enable = 1'b0;
    check_value("busy", {31'b0, busy}, 32'h1);  // high from the cycle after enable
    waited = 0;
    while (busy !== 1'b0 && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (busy !== 1'b0) fail_run("access did not complete, busy stuck high");
  endtask

  // --------------------
  // compare process for loads
  always @(negedge clk) begin : compare_reads
    logic [31:0] exp_value;
    if (data_out_ready === 1'b1) begin
      if (expect_q.size() == 0) fail_run("data_out_ready with no read in flight");
      exp_value = expect_q.pop_front();
      check_value("data_out", data_out, exp_value);
      check_value("busy", {31'b0, busy}, 32'h0);  // ready and busy fall together
    end
  end

  // uart line monitor sampling mid-bit
  initial begin : uart_monitor
    logic [7:0] rx;
    logic [7:0] exp_byte;
    int idle;
    idle = 0;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && uart_tx === 1'b0) begin
        idle = 0;
        if (uart_q.size() == 0) fail_run("start bit on uart_tx with no byte written");
        repeat (ClksPerBit / 2) @(negedge clk);  // middle of start bit
        check_value("uart_tx start bit", {31'b0, uart_tx}, 32'h0);
        for (int i = 0; i < 8; i++) begin
          repeat (ClksPerBit) @(negedge clk);
          rx[i] = uart_tx;  // lsb first
        end
        repeat (ClksPerBit) @(negedge clk);
        check_value("uart_tx stop bit", {31'b0, uart_tx}, 32'h1);
        exp_byte = uart_q.pop_front();
        check_value("uart_tx byte", {24'b0, rx}, {24'b0, exp_byte});
      end else if (uart_q.size() != 0) begin
        idle++;
        if (idle > WaitLimit) fail_run("no start bit on uart_tx for a written byte");
      end else begin
        idle = 0;
      end
    end
  end

  // --------------------
  // stimulus
  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    write_type_t wt;
    read_type_t rt;
    int waited;
    rst_n = 1'b0;
    enable = 1'b0;
    read_type = RT_NONE;
    write_type = WT_NONE;
    address = 32'h0;
    data_in = 32'h0;
    clear_model();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // reset state and zeroed ram
    check_value("busy", {31'b0, busy}, 32'h0);
    check_value("data_out_ready", {31'b0, data_out_ready}, 32'h0);
    check_value("led", {28'b0, led}, 32'h0);
    check_value("uart_tx", {31'b0, uart_tx}, 32'h1);
    for (int n = 0; n < 4; n++) bus_access(next_rand() & 32'h0000_0ffc, WT_NONE, RT_WORD, 32'h0);

    // random aligned traffic over 8 KB so addresses alias mod ram size
    for (int n = 0; n < 300; n++) begin
      r = next_rand();
      addr = next_rand() & 32'h0000_1fff;
      data = next_rand();
      rt = RT_NONE;
      wt = WT_NONE;
      if (r[0]) begin
        case (r[2:1])
          2'd0:    wt = WT_BYTE;
          2'd1:    wt = WT_HALF;
          default: wt = WT_WORD;
        endcase
      end else begin
        case (r[5:3])
          3'd0:    rt = RT_BYTE;
          3'd1:    rt = RT_HALF;
          3'd3:    rt = RT_BYTE_U;
          3'd4:    rt = RT_HALF_U;
          default: rt = RT_WORD;
        endcase
      end
      if (wt == WT_HALF || rt == RT_HALF || rt == RT_HALF_U) addr[0] = 1'b0;
      if (wt == WT_WORD || rt == RT_WORD) addr[1:0] = 2'b00;
      bus_access(addr, wt, rt, data);
    end

    // same index with different tags forces dirty write-back
    bus_access(32'h0000_0010, WT_WORD, RT_NONE, 32'hcafe_f00d);
    bus_access(32'h0000_0050, WT_WORD, RT_NONE, 32'h1234_5678);
    bus_access(32'h0000_0092, WT_HALF, RT_NONE, 32'h0000_beef);
    bus_access(32'h0000_1010, WT_NONE, RT_WORD, 32'h0);  // alias of 0x010
    bus_access(32'h0000_0050, WT_NONE, RT_WORD, 32'h0);

    // led register, nibble with its top bit set
    bus_access(ADDR_LED, WT_BYTE, RT_NONE, 32'h0000_005a);
    check_value("led", {28'b0, led}, {28'b0, model_led});
    bus_access(ADDR_LED, WT_NONE, RT_BYTE, 32'h0);

    // second uart write holds busy until the first byte leaves staging
    bus_access(ADDR_UART_OUT, WT_BYTE, RT_NONE, 32'h0000_0055);
    bus_access(ADDR_UART_OUT, WT_BYTE, RT_NONE, 32'h0000_00c3);
    check_value("uart bytes pending", uart_q.size(), 32'd1);
    bus_access(ADDR_UART_OUT, WT_BYTE, RT_NONE, next_rand());

    waited = 0;
    while (uart_q.size() != 0 && waited < 4 * WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (uart_q.size() != 0) fail_run("uart_tx sent fewer bytes than were written");
    @(negedge clk);  // let the compare process see the last edge

    if (expect_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_run("reads finished without data_out_ready");
    end
  end

endmodule

// ==== tb.f ====
logic/ramio_cfg_pkg.sv
logic/ramio_bus_pkg.sv
logic/burst_ram.sv
logic/line_cache.sv
logic/io_regs.sv
logic/uart_tx.sv
logic/ramio.sv
logic/ramio_top.sv
+incdir+test
test/ramio_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the ramio testbench with verilator, run it, and scan the log for a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f tb.f --top-module ramio_tb -o ramio_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ramio_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
exit 0
